//--- rtl/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

	//////////////////////////////////////////////////
	// Geometry
	//////////////////////////////////////////////////

	localparam int ADDR_W   = 32;                          // Byte address
	localparam int WORD_W   = 32;                          // CPU data word
	localparam int LINE_W   = 256;                         // Eight words per line
	localparam int OFFSET_W = 5;                           // Byte offset within a line
	localparam int INDEX_W  = 3;
	localparam int SETS     = 1 << INDEX_W;
	localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W; // 24 bits

	//////////////////////////////////////////////////
	// Types
	//////////////////////////////////////////////////

	typedef logic [LINE_W-1:0] line_t;

	// Valid and dirty live in resettable flops beside the array, so only the tag is stored here
	typedef struct packed {
		logic [TAG_W-1:0] tag;
	} tag_entry_t;

	typedef struct packed {
		logic              read;
		logic              write;
		logic [ADDR_W-1:0] addr;
		logic [WORD_W-1:0] wdata;
		logic [WORD_W/8-1:0] wmask; // One bit per byte lane
	} mem_req_t;

endpackage

`default_nettype wire

//--- rtl/dcache_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface dcache_ctrl_if;

	//////////////////////////////////////////////////
	// Status from the datapath
	//////////////////////////////////////////////////

	logic hit;
	logic tag0_hit;
	logic tag1_hit;
	logic victim_dirty;      // Dirty bit of the way that lru points at
	logic lru;               // Way to replace in the addressed set
	logic pend_req;          // Stage holds a read or a write
	logic pend_write;        // Stage holds a write

	//////////////////////////////////////////////////
	// Commands from the controller
	//////////////////////////////////////////////////

	logic [1:0] load_data;
	logic [1:0] load_tag;
	logic [1:0] set_valid;
	logic [1:0] set_dirty;
	logic [1:0] clear_dirty;
	logic       load_lru;
	logic       load_stage;  // Pipeline advances at the next edge
	logic       refill_sel;  // Line comes from memory, not from the CPU merge
	logic       wb_addr_sel; // Memory address built from the victim tag

	modport status (
		output hit, tag0_hit, tag1_hit, victim_dirty, lru, pend_req, pend_write,
		input  load_data, load_tag, set_valid, set_dirty, clear_dirty,
		input  load_lru, load_stage, refill_sel, wb_addr_sel
	);

	modport command (
		input  hit, tag0_hit, tag1_hit, victim_dirty, lru, pend_req, pend_write,
		output load_data, load_tag, set_valid, set_dirty, clear_dirty,
		output load_lru, load_stage, refill_sel, wb_addr_sel
	);

endinterface

`default_nettype wire

//--- rtl/dcache_array.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_array #(
	parameter type payload_t = dcache_pkg::line_t
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic [dcache_pkg::INDEX_W-1:0] index,
	input  logic [1:0]                   we,
	input  payload_t                     wdata0,
	input  payload_t                     wdata1,
	output payload_t                     rdata0,
	output payload_t                     rdata1
);

	payload_t way0_mem [dcache_pkg::SETS];
	payload_t way1_mem [dcache_pkg::SETS];

	//////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////

	// Writes are held off while reset is asserted
	always_ff @(posedge clk) begin
		if (rst_n && we[0]) begin
			way0_mem[index] <= wdata0;
		end
		if (rst_n && we[1]) begin
			way1_mem[index] <= wdata1;
		end
	end

	assign rdata0 = way0_mem[index]; // Asynchronous read of both ways
	assign rdata1 = way1_mem[index];

endmodule

`default_nettype wire

//--- rtl/dcache_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_datapath (
	input  logic                           clk,
	input  logic                           rst_n,
	dcache_ctrl_if.status                  ctrl,
	input  logic                           cpu_read,
	input  logic                           cpu_write,
	input  logic [dcache_pkg::ADDR_W-1:0]  cpu_addr,
	input  logic [dcache_pkg::WORD_W-1:0]  cpu_wdata,
	input  logic [dcache_pkg::WORD_W/8-1:0] cpu_wmask,
	output logic [dcache_pkg::WORD_W-1:0]  rdata,
	output logic [dcache_pkg::ADDR_W-1:0]  pmem_addr,
	output dcache_pkg::line_t              pmem_wdata,
	input  dcache_pkg::line_t              pmem_rdata
);

	dcache_pkg::mem_req_t stage_q;

	logic [dcache_pkg::TAG_W-1:0]      req_tag;
	logic [dcache_pkg::INDEX_W-1:0]    req_index;
	logic [dcache_pkg::OFFSET_W-3:0]   word_off;

	dcache_pkg::tag_entry_t tag0;
	dcache_pkg::tag_entry_t tag1;
	dcache_pkg::tag_entry_t tag_wdata;
	dcache_pkg::tag_entry_t victim_tag;

	dcache_pkg::line_t data0;
	dcache_pkg::line_t data1;
	dcache_pkg::line_t hit_line;
	dcache_pkg::line_t merged_line;
	dcache_pkg::line_t line_wdata;

	logic [dcache_pkg::SETS-1:0][1:0] valid_q;
	logic [dcache_pkg::SETS-1:0][1:0] dirty_q;
	logic [dcache_pkg::SETS-1:0]      lru_q;
	logic                             victim_way;

	//////////////////////////////////////////////////
	// Stage register
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			stage_q.read  <= 1'b0;
			stage_q.write <= 1'b0;
		end else if (ctrl.load_stage) begin
			stage_q.read  <= cpu_read;
			stage_q.write <= cpu_write;
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl.load_stage) begin
			stage_q.addr  <= cpu_addr;
			stage_q.wdata <= cpu_wdata;
			stage_q.wmask <= cpu_wmask;
		end
	end

	assign req_tag   = stage_q.addr[dcache_pkg::ADDR_W-1 -: dcache_pkg::TAG_W];
	assign req_index = stage_q.addr[dcache_pkg::OFFSET_W +: dcache_pkg::INDEX_W];
	assign word_off  = stage_q.addr[dcache_pkg::OFFSET_W-1:2]; // Word within the line

	//////////////////////////////////////////////////
	// Tag and data arrays
	//////////////////////////////////////////////////

	assign tag_wdata.tag = req_tag;

	dcache_array #(.payload_t(dcache_pkg::tag_entry_t)) i_tag_array (
		.clk    (clk),
		.rst_n  (rst_n),
		.index  (req_index),
		.we     (ctrl.load_tag),
		.wdata0 (tag_wdata),
		.wdata1 (tag_wdata),
		.rdata0 (tag0),
		.rdata1 (tag1)
	);

	dcache_array #(.payload_t(dcache_pkg::line_t)) i_data_array (
		.clk    (clk),
		.rst_n  (rst_n),
		.index  (req_index),
		.we     (ctrl.load_data),
		.wdata0 (line_wdata),
		.wdata1 (line_wdata),
		.rdata0 (data0),
		.rdata1 (data1)
	);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= '0;
			dirty_q <= '0;
			lru_q   <= '0;
		end else begin
			valid_q[req_index] <= valid_q[req_index] | ctrl.set_valid;
			dirty_q[req_index] <= (dirty_q[req_index] | ctrl.set_dirty) & ~ctrl.clear_dirty;
			if (ctrl.load_lru) begin
				lru_q[req_index] <= ctrl.tag0_hit; // Way 0 used, so way 1 goes next
			end
		end
	end

	//////////////////////////////////////////////////
	// Lookup
	//////////////////////////////////////////////////

	assign ctrl.tag0_hit     = valid_q[req_index][0] && (tag0.tag == req_tag);
	assign ctrl.tag1_hit     = valid_q[req_index][1] && (tag1.tag == req_tag);
	assign ctrl.hit          = ctrl.tag0_hit || ctrl.tag1_hit;
	assign victim_way        = lru_q[req_index];
	assign ctrl.lru          = victim_way;
	assign ctrl.victim_dirty = dirty_q[req_index][victim_way];
	assign ctrl.pend_req     = stage_q.read || stage_q.write;
	assign ctrl.pend_write   = stage_q.write;

	//////////////////////////////////////////////////
	// Result and write paths
	//////////////////////////////////////////////////

	assign hit_line = ctrl.tag1_hit ? data1 : data0;
	assign rdata    = hit_line[word_off*dcache_pkg::WORD_W +: dcache_pkg::WORD_W];

	always_comb begin
		merged_line = hit_line;
		for (int b = 0; b < dcache_pkg::WORD_W/8; b++) begin
			if (stage_q.wmask[b]) begin
				merged_line[word_off*dcache_pkg::WORD_W + b*8 +: 8] = stage_q.wdata[b*8 +: 8];
			end
		end
	end

	assign line_wdata = ctrl.refill_sel ? pmem_rdata : merged_line;

	assign victim_tag = victim_way ? tag1 : tag0;
	assign pmem_wdata = victim_way ? data1 : data0; // Victim line for write-back
	assign pmem_addr  = {ctrl.wb_addr_sel ? victim_tag.tag : req_tag, req_index,
		{dcache_pkg::OFFSET_W{1'b0}}};

endmodule

`default_nettype wire

//--- rtl/dcache_control.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_control (
	input  logic           clk,
	input  logic           rst_n,
	dcache_ctrl_if.command ctrl,
	input  logic           pmem_resp,
	output logic           pmem_read,
	output logic           pmem_write,
	output logic           resp,
	output logic           stall
);

	typedef enum logic [2:0] {
		st_idle,
		st_hit_check,  // Replayed lookup after a refill
		st_write_back,
		st_load,
		st_write_data
	} state_t;

	state_t state;
	state_t next_state;

	logic       check;
	logic [1:0] victim_sel;

	// Idle looks up whatever the stage holds, so a hit answers in the capture cycle plus one
	assign check      = (state == st_hit_check) || (state == st_idle && ctrl.pend_req);
	assign victim_sel = {ctrl.lru, ~ctrl.lru};
	assign stall      = ~ctrl.load_stage;

	//////////////////////////////////////////////////
	// State register and next state
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= st_idle;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		unique case (state)
			st_idle, st_hit_check: begin
				if (!check || ctrl.hit) begin
					next_state = st_idle;
				end else if (ctrl.victim_dirty) begin
					next_state = st_write_back;
				end else begin
					next_state = st_load;
				end
			end
			st_write_back: next_state = pmem_resp ? st_load : st_write_back;
			st_load:       next_state = pmem_resp ? st_write_data : st_load;
			st_write_data: next_state = st_hit_check;
			default:       next_state = st_idle;
		endcase
	end

	//////////////////////////////////////////////////
	// Outputs
	//////////////////////////////////////////////////

	always_comb begin
		ctrl.load_data   = 2'b00;
		ctrl.load_tag    = 2'b00;
		ctrl.set_valid   = 2'b00;
		ctrl.set_dirty   = 2'b00;
		ctrl.clear_dirty = 2'b00;
		ctrl.load_lru    = 1'b0;
		ctrl.load_stage  = 1'b1;
		ctrl.refill_sel  = 1'b0;
		ctrl.wb_addr_sel = 1'b0;
		pmem_read        = 1'b0;
		pmem_write       = 1'b0;
		resp             = 1'b0;

		unique case (state)
			st_idle, st_hit_check: begin
				if (check && ctrl.hit) begin
					resp          = 1'b1;
					ctrl.load_lru = 1'b1;
					if (ctrl.pend_write) begin
						ctrl.load_data = {ctrl.tag1_hit, ctrl.tag0_hit};
						ctrl.set_dirty = {ctrl.tag1_hit, ctrl.tag0_hit};
					end
				end else if (check) begin
					ctrl.load_stage = 1'b0; // Miss holds the pipeline
					if (ctrl.victim_dirty) begin
						pmem_write       = 1'b1;
						ctrl.wb_addr_sel = 1'b1;
					end else begin
						pmem_read = 1'b1;
					end
				end
			end
			st_write_back: begin
				ctrl.load_stage  = 1'b0;
				pmem_write       = 1'b1;
				ctrl.wb_addr_sel = 1'b1;
				if (pmem_resp) begin
					ctrl.clear_dirty = victim_sel;
				end
			end
			st_load: begin
				ctrl.load_stage = 1'b0;
				pmem_read       = 1'b1; // Held through the response cycle
				if (pmem_resp) begin
					ctrl.refill_sel  = 1'b1;
					ctrl.load_data   = victim_sel;
					ctrl.load_tag    = victim_sel;
					ctrl.set_valid   = victim_sel;
					ctrl.clear_dirty = victim_sel;
				end
			end
			st_write_data: begin
				ctrl.load_stage = 1'b0;
			end
			default: begin
				ctrl.load_stage = 1'b1;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/dcache.sv
`timescale 1ns/1ps
`default_nettype none

module dcache (
	input  logic                            clk,
	input  logic                            rst_n,

	// CPU side
	input  logic                            mem_read,
	input  logic                            mem_write,
	input  logic [dcache_pkg::ADDR_W-1:0]   addr,
	input  logic [dcache_pkg::WORD_W-1:0]   wdata,
	input  logic [dcache_pkg::WORD_W/8-1:0] wmask,
	output logic [dcache_pkg::WORD_W-1:0]   rdata,
	output logic                            resp,
	output logic                            stall,

	// Memory side
	output logic                            pmem_read,
	output logic                            pmem_write,
	output logic [dcache_pkg::ADDR_W-1:0]   pmem_addr,
	output dcache_pkg::line_t               pmem_wdata,
	input  dcache_pkg::line_t               pmem_rdata,
	input  logic                            pmem_resp
);

	dcache_ctrl_if ctrl_if ();

	dcache_datapath i_datapath (
		.clk        (clk),
		.rst_n      (rst_n),
		.ctrl       (ctrl_if.status),
		.cpu_read   (mem_read),
		.cpu_write  (mem_write),
		.cpu_addr   (addr),
		.cpu_wdata  (wdata),
		.cpu_wmask  (wmask),
		.rdata      (rdata),
		.pmem_addr  (pmem_addr),
		.pmem_wdata (pmem_wdata),
		.pmem_rdata (pmem_rdata)
	);

	dcache_control i_control (
		.clk        (clk),
		.rst_n      (rst_n),
		.ctrl       (ctrl_if.command),
		.pmem_resp  (pmem_resp),
		.pmem_read  (pmem_read),
		.pmem_write (pmem_write),
		.resp       (resp),
		.stall      (stall)      // Inverse of load_stage
	);

endmodule

`default_nettype wire

//--- sim/pmem_model.sv
`timescale 1ns/1ps
`default_nettype none

module pmem_model #(
	parameter int LATENCY = 6
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          read,
	input  logic                          write,
	input  logic [dcache_pkg::ADDR_W-1:0] addr,
	input  dcache_pkg::line_t             wdata,
	output dcache_pkg::line_t             rdata,
	output logic                          resp
);

	dcache_pkg::line_t lines [logic [26:0]]; // Sparse, keyed by line address
	int count;

	function automatic logic [31:0] pattern_word(logic [31:0] a);
		return a ^ 32'h5a5a_a5a5;
	endfunction

	function automatic dcache_pkg::line_t fetch_line(logic [26:0] line_addr);
		dcache_pkg::line_t l;
		if (lines.exists(line_addr)) begin
			return lines[line_addr];
		end
		for (int w = 0; w < 8; w++) begin
			l[w*32 +: 32] = pattern_word({line_addr, w[2:0], 2'b00});
		end
		return l;
	endfunction

	always @(posedge clk) begin
		if (!rst_n) begin
			resp  <= 1'b0;
			count <= 0;
		end else if ((read || write) && !resp) begin
			if (count == LATENCY - 1) begin
				resp  <= 1'b1;
				count <= 0;
				if (write) begin
					lines[addr[31:5]] = wdata;
				end else begin
					rdata <= fetch_line(addr[31:5]);
				end
			end else begin
				count <= count + 1;
			end
		end else begin
			resp <= 1'b0; // Request drops in the cycle after the response
		end
	end

endmodule

`default_nettype wire

//--- sim/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

	localparam int PMEM_LATENCY = 6;
	localparam int RAND_OPS     = 48;
	localparam int DRAIN_LIMIT  = 2 * PMEM_LATENCY + 6;

	// Kind 0 is a hit, 1 a clean miss, 2 a dirty miss, 3 is not checked for timing
	typedef struct {
		int          test;
		logic        write;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0]  wmask;
		logic [31:0] expect_data;
		int          kind;
		logic [31:0] wb_addr;
		int          cap;
	} op_t;

	logic clk = 1'b0;
	logic rst_n;
	logic mem_read;
	logic mem_write;
	logic [31:0] addr;
	logic [31:0] wdata;
	logic [3:0]  wmask;
	logic [31:0] rdata;
	logic resp;
	logic stall;
	logic pmem_read;
	logic pmem_write;
	logic [31:0] pmem_addr;
	dcache_pkg::line_t pmem_wdata;
	dcache_pkg::line_t pmem_rdata;
	logic pmem_resp;

	op_t ops[$];
	op_t pending[$];
	logic [31:0] shadow [logic [31:0]];
	int cyc = 0;
	int errors = 0;
	int total_ops = 0;
	int reads = 0;
	int writes = 0;
	logic read_after_write = 1'b0;
	logic prev_read = 1'b0;
	logic prev_write = 1'b0;
	logic [31:0] first_wb;

	always #2 clk = ~clk;
	always @(posedge clk) cyc <= cyc + 1;

	dcache i_dcache (
		.clk(clk), .rst_n(rst_n),
		.mem_read(mem_read), .mem_write(mem_write), .addr(addr), .wdata(wdata), .wmask(wmask),
		.rdata(rdata), .resp(resp), .stall(stall),
		.pmem_read(pmem_read), .pmem_write(pmem_write), .pmem_addr(pmem_addr),
		.pmem_wdata(pmem_wdata), .pmem_rdata(pmem_rdata), .pmem_resp(pmem_resp)
	);

	pmem_model #(.LATENCY(PMEM_LATENCY)) i_pmem (
		.clk(clk), .rst_n(rst_n), .read(pmem_read), .write(pmem_write),
		.addr(pmem_addr), .wdata(pmem_wdata), .rdata(pmem_rdata), .resp(pmem_resp)
	);

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	function automatic logic [31:0] pattern_word(logic [31:0] a);
		return a ^ 32'h5a5a_a5a5; // Same rule as the memory model's untouched lines
	endfunction

	function automatic logic [31:0] shadow_word(logic [31:0] a);
		if (shadow.exists(a)) begin
			return shadow[a];
		end
		return pattern_word(a);
	endfunction

	function automatic logic [31:0] merge_word(logic [31:0] old, logic [31:0] d, logic [3:0] m);
		logic [31:0] w;
		w = old;
		for (int b = 0; b < 4; b++) begin
			if (m[b]) w[b*8 +: 8] = d[b*8 +: 8];
		end
		return w;
	endfunction

	function automatic logic [31:0] lcg_next(logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	//////////////////////////////////////////////////
	// Response monitor
	//////////////////////////////////////////////////

	task automatic check_response();
		op_t e;
		assert (pending.size() != 0) else begin
			$display("Response at %0t arrived with no request outstanding", $time);
			errors++;
		end
		if (pending.size() != 0) begin
			e = pending.pop_front();
			if (!e.write) begin
				assert (rdata === e.expect_data) else begin
					$display("Fail %0t: addr %h expected %h got %h", $time, e.addr,
						e.expect_data, rdata);
					errors++;
				end
			end
			case (e.kind)
				0: assert (cyc == e.cap && !stall && reads == 0 && writes == 0) else begin
					$display("Access to %h at %0t should have hit without stall after capture",
						e.addr, $time);
					errors++;
				end
				1: assert (reads == 1 && writes == 0) else begin
					$display("Access to %h at %0t should have been a clean miss", e.addr, $time);
					errors++;
				end
				2: assert (writes == 1 && reads == 1 && read_after_write
					&& first_wb == e.wb_addr) else begin
					$display("Access to %h at %0t did not write back %h before the refill", e.addr,
						$time, e.wb_addr);
					errors++;
				end
				default: ;
			endcase
		end
		reads = 0;
		writes = 0;
		read_after_write = 1'b0;
	endtask

	always @(negedge clk) begin
		if (rst_n) begin
			if (pmem_write && !prev_write) begin
				if (writes == 0) first_wb = pmem_addr;
				writes++;
			end
			if (pmem_read && !prev_read) begin
				reads++;
				if (writes != 0) read_after_write = 1'b1;
			end
			prev_read = pmem_read;
			prev_write = pmem_write;
			if (resp) check_response();
		end
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	function automatic logic read_stimulus();
		int fd;
		int n;
		int r;
		string line;
		op_t e;
		fd = $fopen("sim/dcache_stim.txt", "r");
		if (fd == 0) return 1'b0;
		while (!$feof(fd)) begin
			r = $fgets(line, fd);
			n = $sscanf(line, "%d %h %h %h %h %h %d %h", e.test, e.write, e.addr, e.wdata,
				e.wmask, e.expect_data, e.kind, e.wb_addr);
			if (r != 0 && n == 8) ops.push_back(e); // Comment and blank lines fall out here
		end
		$fclose(fd);
		return 1'b1;
	endfunction

	task automatic add_random_ops();
		logic [31:0] s;
		op_t e;
		s = 32'h6174_3f46;
		for (int i = 0; i < RAND_OPS; i++) begin
			s = lcg_next(s);
			e.test = 6;
			e.write = s[28];
			// Three tags per set
			e.addr = {24'h000100 + 24'(s[31:16] % 3), s[10:8], s[14:12], 2'b00};
			s = lcg_next(s);
			e.wdata = s;
			e.wmask = s[23:20];
			e.kind = 3;
			e.expect_data = 32'h0;
			e.wb_addr = 32'h0;
			ops.push_back(e);
		end
	endtask

	task automatic issue_op(op_t e);
		mem_read = !e.write;
		mem_write = e.write;
		addr = e.addr;
		wdata = e.wdata;
		wmask = e.wmask;
		@(negedge clk);
		while (stall) @(negedge clk);
		e.cap = cyc + 1;
		if (e.kind == 3 && !e.write) e.expect_data = shadow_word(e.addr);
		if (e.write) shadow[e.addr] = merge_word(shadow_word(e.addr), e.wdata, e.wmask);
		pending.push_back(e);
		@(posedge clk);
		#1;
	endtask

	task automatic finish_test(int test, int count, int err_start);
		int waited;
		mem_read = 1'b0;
		mem_write = 1'b0;
		waited = 0;
		while (pending.size() != 0 && waited < DRAIN_LIMIT * 2) begin
			@(negedge clk);
			waited++;
		end
		@(posedge clk);
		#1;
		assert (pending.size() == 0) else begin
			$display("Test %0d: a response did not arrive in time", test);
			errors++;
			pending.delete();
		end
		$display("Test %0d: %0d operations, %0d errors", test, count, errors - err_start);
	endtask

	initial begin
		wait (total_ops != 0);
		#(total_ops * (2 * PMEM_LATENCY + 6) * 4 + 5 * 4);
		$display("Watchdog expired with %0d responses outstanding", pending.size());
		$display("Regression failed");
		$finish;
	end

	initial begin
		int cur;
		int count;
		int err_start;
		int tests;
		rst_n = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		addr = 32'h0;
		wdata = 32'h0;
		wmask = 4'h0;
		if (!read_stimulus()) begin
			$display("Could not open the stimulus file sim/dcache_stim.txt");
			$display("Regression failed");
			$finish;
		end else begin
			add_random_ops();
			total_ops = ops.size();
			repeat (5) @(posedge clk);
			#1;
			rst_n = 1'b1;
			cur = ops[0].test;
			count = 0;
			err_start = errors;
			tests = 1;
			foreach (ops[i]) begin
				if (ops[i].test != cur) begin
					finish_test(cur, count, err_start);
					cur = ops[i].test;
					count = 0;
					err_start = errors;
					tests++;
				end
				issue_op(ops[i]);
				count++;
			end
			finish_test(cur, count, err_start);
			$display("Summary: %0d tests, %0d operations, %0d errors", tests, total_ops, errors);
			if (errors == 0) begin
				$display("Regression passed");
			end else begin
				$display("Regression failed");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- sim/dcache_stim.txt
# test op(0 read, 1 write) addr wdata wmask expect kind(0 hit, 1 clean miss, 2 dirty miss) wb_addr
# All numbers are hex except test and kind
1 0 00001040 00000000 0 5a5ab5e5 1 00000000
1 0 00001040 00000000 0 5a5ab5e5 0 00000000
1 0 00001044 00000000 0 5a5ab5e1 0 00000000
2 1 00001044 11223344 3 00000000 0 00000000
2 0 00001044 00000000 0 5a5a3344 0 00000000
2 1 00001048 aabbccdd c 00000000 0 00000000
2 0 00001048 00000000 0 aabbb5ed 0 00000000
3 0 00002060 00000000 0 5a5a85c5 1 00000000
3 0 00003060 00000000 0 5a5a95c5 1 00000000
3 0 00002060 00000000 0 5a5a85c5 0 00000000
3 0 00003064 00000000 0 5a5a95c1 0 00000000
3 0 00002068 00000000 0 5a5a85cd 0 00000000
3 0 00003060 00000000 0 5a5a95c5 0 00000000
4 0 000040a0 00000000 0 5a5ae505 1 00000000
4 0 000050a0 00000000 0 5a5af505 1 00000000
4 0 000040a0 00000000 0 5a5ae505 0 00000000
4 0 000060a0 00000000 0 5a5ac505 1 00000000
4 0 000040a0 00000000 0 5a5ae505 0 00000000
4 0 000050a0 00000000 0 5a5af505 1 00000000
5 1 000070c0 deadbeef f 00000000 1 00000000
5 1 000070c4 0badf00d f 00000000 0 00000000
5 0 000080c0 00000000 0 5a5a2565 1 00000000
5 0 000090c0 00000000 0 5a5a3565 2 000070c0
5 0 000070c0 00000000 0 deadbeef 1 00000000
5 0 000070c4 00000000 0 0badf00d 0 00000000

//--- build.f
rtl/dcache_pkg.sv
rtl/dcache_ctrl_if.sv
rtl/dcache_array.sv
rtl/dcache_datapath.sv
rtl/dcache_control.sv
rtl/dcache.sv
sim/pmem_model.sv
sim/dcache_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = dcache_tb
FILELIST = build.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
